//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and register index widths
`define REG_BUS_WIDTH  32
`define REG_ADDR_WIDTH 5
`define FUNC3_WIDTH    3

// Data RAM size in words, and the word address width that goes with it
`define DMEM_DEPTH     256
`define DMEM_AW        8

// Pipeline depth, IF through WB
`define STAGE_NUM      5

// Value of an empty data or address field
`define ZERO_WORD      32'h0000_0000

`endif

//--- rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    // Stage indices, these address bits of the stall vector
    typedef enum logic [2:0] {
        IF_STAGE = 3'd0,
        ID_STAGE = 3'd1,
        EX_STAGE = 3'd2,
        ME_STAGE = 3'd3,
        WB_STAGE = 3'd4
    } stage_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SLT   = 4'd7,   // Signed compare
        ALU_PASSB = 4'd8    // Second operand straight through
    } alu_op_e;

    // Load/store width codes, same values as the RISC-V func3 field
    typedef enum logic [`FUNC3_WIDTH-1:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } mem_func3_e;

    // One bit per stage, set means the stage holds its contents
    typedef logic [`STAGE_NUM-1:0] stall_t;

endpackage

`default_nettype wire

//--- rtl/ex_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

interface ex_mem_if;

    logic [`REG_BUS_WIDTH-1:0]  pc;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       wreg;
    logic [`REG_BUS_WIDTH-1:0]  wdata;      // ALU result or memory address
    logic [`REG_BUS_WIDTH-1:0]  wreg_data;  // Store data
    logic                       memrd;
    logic                       memwr;
    logic [`FUNC3_WIDTH-1:0]    func3;
    logic                       in_delayslot;

    modport producer (
        output pc, rd, wreg, wdata, wreg_data,
        output memrd, memwr, func3, in_delayslot
    );

    modport consumer (
        input pc, rd, wreg, wdata, wreg_data,
        input memrd, memwr, func3, in_delayslot
    );

endinterface

`default_nettype wire

//--- rtl/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module ex_stage
    import cpu_pkg::*;
(
    input  logic [`REG_BUS_WIDTH-1:0]  pc,
    input  logic [`REG_BUS_WIDTH-1:0]  op_a,
    input  logic [`REG_BUS_WIDTH-1:0]  op_b,
    input  logic [`REG_BUS_WIDTH-1:0]  imm,
    input  logic                       use_imm,
    input  alu_op_e                    alu_op,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       wreg,
    input  logic                       memrd,
    input  logic                       memwr,
    input  logic [`FUNC3_WIDTH-1:0]    func3,
    input  logic                       in_delayslot,

    ex_mem_if.producer                 ex_bus
);

    localparam int SHAMT_W = $clog2(`REG_BUS_WIDTH);

    logic [`REG_BUS_WIDTH-1:0] alu_b;
    logic [`REG_BUS_WIDTH-1:0] alu_res;
    logic [`REG_BUS_WIDTH-1:0] mem_addr;
    logic                      is_mem;

    assign alu_b    = use_imm ? imm : op_b;
    assign mem_addr = op_a + imm;   // Loads and stores always add the offset
    assign is_mem   = memrd | memwr;

    always_comb begin
        case (alu_op)
            ALU_ADD:   alu_res = op_a + alu_b;
            ALU_SUB:   alu_res = op_a - alu_b;
            ALU_AND:   alu_res = op_a & alu_b;
            ALU_OR:    alu_res = op_a | alu_b;
            ALU_XOR:   alu_res = op_a ^ alu_b;
            ALU_SLL:   alu_res = op_a << alu_b[SHAMT_W-1:0];
            ALU_SRL:   alu_res = op_a >> alu_b[SHAMT_W-1:0];
            ALU_SLT:   alu_res = `REG_BUS_WIDTH'($signed(op_a) < $signed(alu_b));
            ALU_PASSB: alu_res = alu_b;
            default:   alu_res = `ZERO_WORD;
        endcase
    end

    // Address replaces the ALU result for memory operations
    assign ex_bus.wdata        = is_mem ? mem_addr : alu_res;
    assign ex_bus.wreg_data    = op_b;
    assign ex_bus.pc           = pc;
    assign ex_bus.rd           = rd;
    assign ex_bus.wreg         = wreg;
    assign ex_bus.memrd        = memrd;
    assign ex_bus.memwr        = memwr;
    assign ex_bus.func3        = func3;
    assign ex_bus.in_delayslot = in_delayslot;

endmodule

`default_nettype wire

//--- rtl/ex_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module ex_mem
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  stall_t     stall,
    input  logic       flush,

    ex_mem_if.consumer ex_bus,
    ex_mem_if.producer mem_bus
);

    logic load_bubble;

    // EX holds while ME keeps running, so ME must see an empty slot
    assign load_bubble = flush | (stall[EX_STAGE] & ~stall[ME_STAGE]);

    always_ff @(posedge clk, negedge rstn) begin
        if (!rstn) begin
            mem_bus.pc           <= `ZERO_WORD;
            mem_bus.rd           <= '0;
            mem_bus.wreg         <= 1'b0;
            mem_bus.wdata        <= `ZERO_WORD;
            mem_bus.wreg_data    <= `ZERO_WORD;
            mem_bus.memrd        <= 1'b0;
            mem_bus.memwr        <= 1'b0;
            mem_bus.func3        <= '0;
            mem_bus.in_delayslot <= 1'b0;
        end else if (load_bubble) begin
            mem_bus.pc           <= `ZERO_WORD;
            mem_bus.rd           <= '0;
            mem_bus.wreg         <= 1'b0;
            mem_bus.wdata        <= `ZERO_WORD;
            mem_bus.wreg_data    <= `ZERO_WORD;
            mem_bus.memrd        <= 1'b0;
            mem_bus.memwr        <= 1'b0;
            mem_bus.func3        <= '0;
            mem_bus.in_delayslot <= 1'b0;
        end else if (!stall[ME_STAGE]) begin
            mem_bus.pc           <= ex_bus.pc;
            mem_bus.rd           <= ex_bus.rd;
            mem_bus.wreg         <= ex_bus.wreg;
            mem_bus.wdata        <= ex_bus.wdata;
            mem_bus.wreg_data    <= ex_bus.wreg_data;
            mem_bus.memrd        <= ex_bus.memrd;
            mem_bus.memwr        <= ex_bus.memwr;
            mem_bus.func3        <= ex_bus.func3;
            mem_bus.in_delayslot <= ex_bus.in_delayslot;
        end
        // ME stalled with no flush keeps the current instruction
    end

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module mem_stage
    import cpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    ex_mem_if.consumer                 mem_bus,
    input  stall_t                     stall,

    output logic                       mem_stall_req,
    output logic                       wb_we,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`REG_BUS_WIDTH-1:0]  wb_data,
    output logic [`REG_BUS_WIDTH-1:0]  wb_pc,
    output logic                       wb_in_delayslot
);

    logic [`REG_BUS_WIDTH-1:0] dmem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0]       word_addr;
    logic [1:0]                byte_off;
    logic [3:0]                store_be;
    logic [`REG_BUS_WIDTH-1:0] store_data;
    logic [`REG_BUS_WIDTH-1:0] rdata;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;
    logic [`REG_BUS_WIDTH-1:0] load_data;
    logic                      load_wait;   // Second ME cycle of a load

    assign word_addr = mem_bus.wdata[`DMEM_AW+1:2];
    assign byte_off  = mem_bus.wdata[1:0];

    // Narrow stores are replicated across the word and masked by byte enables
    always_comb begin
        store_be   = 4'b1111;
        store_data = mem_bus.wreg_data;
        case (mem_func3_e'(mem_bus.func3))
            F3_B, F3_BU: begin
                store_be   = 4'b0001 << byte_off;
                store_data = {4{mem_bus.wreg_data[7:0]}};
            end
            F3_H, F3_HU: begin
                store_be   = 4'b0011 << {byte_off[1], 1'b0};
                store_data = {2{mem_bus.wreg_data[15:0]}};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_bus.memwr && !stall[ME_STAGE]) begin
            for (int i = 0; i < 4; i++) begin
                if (store_be[i]) dmem[word_addr][8*i +: 8] <= store_data[8*i +: 8];
            end
        end
        if (mem_stall_req) rdata <= dmem[word_addr];  // Read issued in the first load cycle
    end

    assign mem_stall_req = mem_bus.memrd & ~load_wait;

    always_ff @(posedge clk, negedge rstn) begin
        if (!rstn) load_wait <= 1'b0;
        else       load_wait <= mem_stall_req;
    end

    assign ld_byte = rdata[{byte_off, 3'b000} +: 8];
    assign ld_half = rdata[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_func3_e'(mem_bus.func3))
            F3_B:    load_data = {{24{ld_byte[7]}}, ld_byte};
            F3_BU:   load_data = {24'd0, ld_byte};
            F3_H:    load_data = {{16{ld_half[15]}}, ld_half};
            F3_HU:   load_data = {16'd0, ld_half};
            default: load_data = rdata;
        endcase
    end

    // A stalled ME cycle sends a bubble to writeback
    always_ff @(posedge clk, negedge rstn) begin
        if (!rstn) wb_we <= 1'b0;
        else       wb_we <= mem_bus.wreg & ~stall[ME_STAGE];
    end

    always_ff @(posedge clk) begin
        wb_rd           <= mem_bus.rd;
        wb_data         <= mem_bus.memrd ? load_data : mem_bus.wdata;
        wb_pc           <= mem_bus.pc;
        wb_in_delayslot <= mem_bus.in_delayslot;
    end

endmodule

`default_nettype wire

//--- rtl/pipe_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module pipe_ctrl
    import cpu_pkg::*;
(
    input  logic   ex_stall_req,
    input  logic   mem_stall_req,
    output stall_t stall
);

    logic [`STAGE_NUM-1:0] req;
    logic                  hold_acc;

    always_comb begin
        req           = '0;
        req[EX_STAGE] = ex_stall_req;
        req[ME_STAGE] = mem_stall_req;
    end

    // Walk from WB toward IF; once a stage requests, every earlier stage holds too
    always_comb begin
        hold_acc = 1'b0;
        stall    = '0;
        for (int k = `STAGE_NUM - 1; k >= 0; k--) begin
            hold_acc = hold_acc | req[k];
            stall[k] = hold_acc;
        end
        stall[WB_STAGE] = 1'b0;  // WB always retires
    end

endmodule

`default_nettype wire

//--- rtl/cpu_backend.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_backend
    import cpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,

    input  logic [`REG_BUS_WIDTH-1:0]  pc,
    input  logic [`REG_BUS_WIDTH-1:0]  op_a,
    input  logic [`REG_BUS_WIDTH-1:0]  op_b,
    input  logic [`REG_BUS_WIDTH-1:0]  imm,
    input  logic                       use_imm,
    input  alu_op_e                    alu_op,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       wreg,
    input  logic                       memrd,
    input  logic                       memwr,
    input  logic [`FUNC3_WIDTH-1:0]    func3,
    input  logic                       in_delayslot,

    input  logic                       ex_stall_req,
    input  logic                       flush,
    output logic                       hold,

    output logic                       wb_we,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`REG_BUS_WIDTH-1:0]  wb_data,
    output logic [`REG_BUS_WIDTH-1:0]  wb_pc,
    output logic                       wb_in_delayslot
);

    stall_t stall;
    logic   mem_stall_req;

    ex_mem_if ex_bus ();
    ex_mem_if mem_bus ();

    assign hold = stall[EX_STAGE];  // Upstream keeps its inputs steady while high

    ex_stage u_ex_stage (
        .pc           (pc),
        .op_a         (op_a),
        .op_b         (op_b),
        .imm          (imm),
        .use_imm      (use_imm),
        .alu_op       (alu_op),
        .rd           (rd),
        .wreg         (wreg),
        .memrd        (memrd),
        .memwr        (memwr),
        .func3        (func3),
        .in_delayslot (in_delayslot),
        .ex_bus       (ex_bus.producer)
    );

    ex_mem u_ex_mem (
        .clk     (clk),
        .rstn    (rstn),
        .stall   (stall),
        .flush   (flush),
        .ex_bus  (ex_bus.consumer),
        .mem_bus (mem_bus.producer)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .rstn            (rstn),
        .mem_bus         (mem_bus.consumer),
        .stall           (stall),
        .mem_stall_req   (mem_stall_req),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .wb_pc           (wb_pc),
        .wb_in_delayslot (wb_in_delayslot)
    );

    pipe_ctrl u_pipe_ctrl (
        .ex_stall_req  (ex_stall_req),
        .mem_stall_req (mem_stall_req),
        .stall         (stall)
    );

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rstn
);

    initial clk = 1'b0;

    always #10 clk = ~clk;  // 20 ns period

    // Reset released a little after the third rising edge
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #2 rstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/cpu_backend_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_backend_assert (
    input wire logic clk,
    input wire logic rstn,
    input wire logic hold,
    input wire logic ex_stall_req,
    input wire logic mem_stall_req,
    input wire logic wb_we
);

    // Upstream may only be held by a load waiting in ME or by an external request
    hold_has_cause: assert property (@(posedge clk) disable iff (!rstn)
        hold |-> (mem_stall_req || ex_stall_req))
        else $error("hold is high with no load in ME and no ex_stall_req");

    // Nothing has been issued yet in the first cycle out of reset
    no_wb_after_reset: assert property (@(posedge clk)
        (rstn && !$past(rstn)) |=> !wb_we)
        else $error("wb_we is high in the first cycle after reset");

    // A load holds upstream for its first ME cycle only
    load_wait_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        mem_stall_req |=> (!mem_stall_req && (!hold || ex_stall_req)))
        else $error("mem_stall_req or hold lasts more than one cycle for a load");

endmodule

bind cpu_backend cpu_backend_assert u_cpu_backend_assert (.*);

`default_nettype wire

//--- verification/cpu_backend_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_backend_tb
    import cpu_pkg::*;
();

    localparam int NUM_INSTR = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 7 + 200;  // Worst case a load under a stall span
    localparam logic [31:0] BASE = 32'h0000_0100;      // 64-byte data window

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
        logic        ds;
        int          due;
    } wb_item_t;

    logic clk, rstn;
    logic [31:0] pc, op_a, op_b, imm;
    logic use_imm, wreg, memrd, memwr, in_delayslot, ex_stall_req, flush, hold;
    alu_op_e alu_op;
    logic [4:0] rd;
    logic [2:0] func3;
    logic wb_we, wb_in_delayslot;
    logic [4:0] wb_rd;
    logic [31:0] wb_data, wb_pc;

    logic [7:0] mem_model [0:63];
    wb_item_t exp_q [$];
    logic [2:0] f3_list [0:4] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    int seed = 32'h4f67;
    int cyc = 0;
    int errors = 0;
    int checked = 0;

    tb_clkgen u_tb_clkgen (.clk(clk), .rstn(rstn));

    cpu_backend u_cpu_backend (.*);

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] expected_wb(input alu_op_e op, input logic [31:0] a,
            input logic [31:0] b, input logic [31:0] im, input logic ui, input logic rd_mem,
            input logic [2:0] f3);
        logic [31:0] bv;
        logic [7:0]  by;
        logic [15:0] hw;
        int          off;
        bv = ui ? im : b;
        if (rd_mem) begin
            off = int'(a + im - BASE);
            by  = mem_model[off];
            hw  = {mem_model[off | 1], mem_model[off & ~1]};
            case (f3)
                3'b000:  return {{24{by[7]}}, by};
                3'b100:  return {24'd0, by};
                3'b001:  return {{16{hw[15]}}, hw};
                3'b101:  return {16'd0, hw};
                default: return {mem_model[off + 3], mem_model[off + 2],
                                 mem_model[off + 1], mem_model[off]};
            endcase
        end
        case (op)
            ALU_ADD: return a + bv;
            ALU_SUB: return a - bv;
            ALU_AND: return a & bv;
            ALU_OR:  return a | bv;
            ALU_XOR: return a ^ bv;
            ALU_SLL: return a << bv[4:0];
            ALU_SRL: return a >> bv[4:0];
            ALU_SLT: return {31'd0, $signed(a) < $signed(bv)};
            default: return bv;
        endcase
    endfunction

    task automatic store_model(input logic [31:0] addr, input logic [2:0] f3,
            input logic [31:0] d);
        int off;
        off = int'(addr - BASE);
        mem_model[off] = d[7:0];
        if (f3 != 3'b000) mem_model[off + 1] = d[15:8];
        if (f3 == 3'b010) begin
            mem_model[off + 2] = d[23:16];
            mem_model[off + 3] = d[31:24];
        end
    endtask

    // Picks the next instruction; the first 16 fill the data window with word stores
    task automatic next_instr(input int n);
        logic [31:0] r, off, k;
        r = $random(seed);
        pc = 32'(n) << 2;
        in_delayslot = r[9];
        rd = 5'($random(seed));
        op_a = $random(seed);
        op_b = $random(seed);
        imm = $random(seed);
        use_imm = r[8];
        alu_op = alu_op_e'(4'(r[31:16] % 16'd9));
        func3 = 3'b010;
        memrd = 1'b0;
        memwr = 1'b0;
        wreg = 1'b1;
        if (n < 16 || (r[3:0] >= 4'd7 && r[3:0] <= 4'd10)) begin
            memwr = 1'b1;
            wreg = 1'b0;
            if (n >= 16) func3 = f3_list[int'(r[15:12]) % 3];
        end else if (r[3:0] >= 4'd11) begin
            memrd = 1'b1;
            func3 = f3_list[int'(r[15:12]) % 5];
        end else begin
            wreg = r[6:4] != 3'd0;  // Some ALU ops write nothing back
        end
        if (memrd || memwr) begin
            off = (n < 16) ? 32'(n) << 2 : ($random(seed) & 32'h3f);
            if (func3[1:0] == 2'b01) off = off & ~32'h1;
            if (func3 == 3'b010) off = off & ~32'h3;
            k = $random(seed) & 32'hff;
            op_a = BASE + off - k;
            imm = k;
        end
    endtask

    initial begin
        int n;
        int span;
        logic fl;
        logic pending;
        pc = '0; op_a = '0; op_b = '0; imm = '0; use_imm = 1'b0; alu_op = ALU_ADD;
        rd = '0; wreg = 1'b0; memrd = 1'b0; memwr = 1'b0; func3 = '0;
        in_delayslot = 1'b0; ex_stall_req = 1'b0; flush = 1'b0;
        n = 0;
        span = 0;
        pending = 1'b0;
        @(posedge rstn);
        repeat (3) begin
            @(negedge clk);
            if (wb_we || hold) begin
                errors++;
                $display("wb_we or hold went high after reset before any issue at %0t", $time);
            end
        end
        while (n < NUM_INSTR) begin
            @(posedge clk);
            #2;
            if (span > 0) span--;
            else if (n >= 16 && ($random(seed) & 7) == 0) span = ($random(seed) & 3) + 1;
            ex_stall_req = span > 0;
            if (!pending) next_instr(n);
            pending = 1'b1;
            #1;
            fl = !hold && n >= 16 && ($random(seed) & 15) == 0;
            flush = fl;
            @(negedge clk);
            if (!hold) begin  // Captured at the coming edge unless flushed
                if (!fl && wreg)
                    exp_q.push_back('{rd, expected_wb(alu_op, op_a, op_b, imm, use_imm, memrd,
                                     func3), pc, in_delayslot, cyc + (memrd ? 3 : 2)});
                if (!fl && memwr) store_model(op_a + imm, func3, op_b);
                pending = 1'b0;
                n++;
            end
        end
        @(posedge clk);
        #2;
        wreg = 1'b0; memrd = 1'b0; memwr = 1'b0; flush = 1'b0; ex_stall_req = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Writebacks checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(negedge clk) begin
        wb_item_t e;
        if (rstn && wb_we) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("wb_we high at %0t with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                checked++;
                if (wb_data !== e.data) begin
                    errors++;
                    $display("FAILED %0t wb_data got %h expected %h", $time, wb_data, e.data);
                end
                if (wb_rd !== e.rd) begin
                    errors++;
                    $display("FAILED %0t wb_rd got %0d expected %0d", $time, wb_rd, e.rd);
                end
                if (wb_pc !== e.pc) begin
                    errors++;
                    $display("FAILED %0t wb_pc got %h expected %h", $time, wb_pc, e.pc);
                end
                if (wb_in_delayslot !== e.ds) begin
                    errors++;
                    $display("FAILED %0t wb_in_delayslot got %b expected %b", $time,
                             wb_in_delayslot, e.ds);
                end
                if (cyc != e.due) begin
                    errors++;
                    $display("FAILED %0t wb cycle got %0d expected %0d", $time, cyc, e.due);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d writebacks outstanding", cyc,
                     exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/ex_mem_if.sv
rtl/ex_stage.sv
rtl/ex_mem.sv
rtl/mem_stage.sv
rtl/pipe_ctrl.sv
rtl/cpu_backend.sv
verification/tb_clkgen.sv
verification/cpu_backend_assert.sv
verification/cpu_backend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module cpu_backend_tb -o cpu_backend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpu_backend_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
